// ==== all.f ====
verilog/player_pkg.sv
verilog/axil_pkg.sv
verilog/command_decoder.sv
verilog/sample_rate_gen.sv
verilog/flash_axil_reader.sv
verilog/sample_sequencer.sv
verilog/audio_player_top.sv
testbench/flash_axil_model.sv
testbench/tb_audio_player.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the audio player testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

verilator --binary --assert --timing --timescale 1ns/1ps \
  --top-module tb_audio_player -f all.f

./obj_dir/Vtb_audio_player

// ==== testbench/flash_axil_model.sv ====
`default_nettype none

module flash_axil_model #(
  parameter int SONG_WORDS = 8
) (
  input  wire                     CLK_50M,
  input  wire                     rst_n,
  input  wire axil_pkg::axil_ar_t ar,
  output logic                    ar_ready,
  output axil_pkg::axil_r_t       r
);

  timeunit 1ns;
  timeprecision 1ps;

  localparam int IDX_W = $clog2(SONG_WORDS);

  // Song words, loaded by the testbench
  logic [axil_pkg::DATA_W-1:0] mem [SONG_WORDS];

  initial
  begin : serve_reads
    int               delay;
    logic [IDX_W-1:0] index;
    ar_ready = 1'b0;
    r        = '0;
    forever
    begin
      @(negedge CLK_50M);
      if (rst_n && ar.valid)
      begin
        // Address back-pressure of 0 to 3 cycles
        delay = int'($urandom_range(3, 0));
        repeat (delay) @(negedge CLK_50M);
        index    = IDX_W'(ar.addr >> 2);
        ar_ready = 1'b1;
        @(negedge CLK_50M);
        ar_ready = 1'b0;
        // Data latency
        delay = int'($urandom_range(3, 0));
        repeat (delay) @(negedge CLK_50M);
        r.valid = 1'b1;
        r.data  = mem[index];
        r.resp  = axil_pkg::RESP_OKAY;
        @(negedge CLK_50M);
        r = '0;
      end
    end
  end

endmodule

`default_nettype wire

// ==== testbench/tb_audio_player.sv ====
`default_nettype none

module tb_audio_player;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int SONG_WORDS     = 8;
  localparam int DEFAULT_PERIOD = 40;
  localparam int PERIOD_STEP    = 8;
  localparam int MIN_PERIOD     = 16;
  localparam int MAX_PERIOD     = 64;
  localparam int SEED           = 9;
  localparam logic [axil_pkg::ADDR_W-1:0] ADDR_LIMIT = axil_pkg::ADDR_W'(SONG_WORDS * 4);

  logic                       CLK_50M = 1'b0;
  logic                       rst_n;
  logic [7:0]                 key_ascii;
  logic                       key_valid;
  logic                       speed_up;
  logic                       speed_down;
  logic                       speed_reset;
  logic [15:0]                period;
  player_pkg::player_status_t status;
  player_pkg::sample_t        sample;
  axil_pkg::axil_ar_t         ar;
  logic                       ar_ready;
  axil_pkg::axil_r_t          r;
  logic                       r_ready;

  // Reference state
  logic [31:0]             song [SONG_WORDS];
  int                      ref_word;
  int                      ref_byte;
  int                      sample_count;
  int                      cyc;
  int                      last_cyc;
  int                      gap;
  logic                    gap_armed;
  logic                    restart_due;
  logic                    started;
  logic [2:0]              keys_prev;
  logic [15:0]             exp_period;
  logic [7:0]              exp_byte;
  player_pkg::play_state_e exp_play;
  player_pkg::dir_e        exp_dir;
  player_pkg::dir_e        dir_prev;
  logic                    reset_idle;
  logic                    quiet;
  logic                    ar_wait_q;
  axil_pkg::axil_ar_t      ar_q;
  logic                    rd_busy;

  audio_player_top #(
    .SONG_WORDS     (SONG_WORDS),
    .DEFAULT_PERIOD (DEFAULT_PERIOD),
    .PERIOD_STEP    (PERIOD_STEP),
    .MIN_PERIOD     (MIN_PERIOD),
    .MAX_PERIOD     (MAX_PERIOD)
  ) dut0 (
    .CLK_50M     (CLK_50M),
    .rst_n       (rst_n),
    .key_ascii   (key_ascii),
    .key_valid   (key_valid),
    .speed_up    (speed_up),
    .speed_down  (speed_down),
    .speed_reset (speed_reset),
    .period      (period),
    .status      (status),
    .sample      (sample),
    .ar          (ar),
    .ar_ready    (ar_ready),
    .r           (r),
    .r_ready     (r_ready)
  );

  flash_axil_model #(
    .SONG_WORDS (SONG_WORDS)
  ) flash0 (
    .CLK_50M  (CLK_50M),
    .rst_n    (rst_n),
    .ar       (ar),
    .ar_ready (ar_ready),
    .r        (r)
  );

  always #10 CLK_50M = ~CLK_50M;

  assign exp_byte = song[ref_word][ref_byte * 8 +: 8];
  assign gap      = cyc - last_cyc;

  task automatic report_and_stop(input string msg);
    $display("%s", msg);
    $display("FAIL: see errors above");
    $fatal(1);
  endtask

  // ========================================
  // Reference model
  // ========================================

  always @(posedge CLK_50M or negedge rst_n)
  begin : reference_model
    int         w;
    int         b;
    int         p;
    logic       armed;
    logic [2:0] keys;
    if (!rst_n)
    begin
      ref_word     <= 0;
      ref_byte     <= 0;
      sample_count <= 0;
      cyc          <= 0;
      last_cyc     <= 0;
      gap_armed    <= 1'b0;
      restart_due  <= 1'b0;
      started      <= 1'b0;
      keys_prev    <= 3'b000;
      exp_period   <= 16'(DEFAULT_PERIOD);
      exp_play     <= player_pkg::STOPPED;
      exp_dir      <= player_pkg::FWD;
      dir_prev     <= player_pkg::FWD;
    end
    else
    begin
      w     = ref_word;
      b     = ref_byte;
      armed = gap_armed;
      cyc      <= cyc + 1;
      dir_prev <= exp_dir;
      // Step uses the direction seen on the tick cycle
      if (sample.valid)
      begin
        sample_count <= sample_count + 1;
        last_cyc     <= cyc;
        armed = 1'b1;
        if (dir_prev == player_pkg::FWD)
        begin
          b = b + 1;
          if (b == 4)
          begin
            b = 0;
            w = (w + 1) % SONG_WORDS;
          end
        end
        else
        begin
          b = b - 1;
          if (b < 0)
          begin
            b = 3;
            w = (w + SONG_WORDS - 1) % SONG_WORDS;
          end
        end
      end
      if (restart_due)
      begin
        armed = 1'b0;
        w = (exp_dir == player_pkg::FWD) ? 0 : SONG_WORDS - 1;
        b = (exp_dir == player_pkg::FWD) ? 0 : 3;
      end
      restart_due <= 1'b0;
      if (key_valid)
      begin
        case (key_ascii)
          player_pkg::key_start:
          begin
            exp_play    <= player_pkg::PLAYING;
            restart_due <= !started;
            started     <= 1'b1;
          end
          player_pkg::key_stop:     exp_play    <= player_pkg::STOPPED;
          player_pkg::key_backward: exp_dir     <= player_pkg::BWD;
          player_pkg::key_forward:  exp_dir     <= player_pkg::FWD;
          player_pkg::key_restart:  restart_due <= 1'b1;
          default:                  restart_due <= 1'b0;
        endcase
      end
      // Speed keys act on rising edges only
      keys = {speed_reset, speed_down, speed_up};
      p = int'(exp_period);
      if (keys[2] && !keys_prev[2])
        p = DEFAULT_PERIOD;
      else if (keys[0] && !keys_prev[0])
        p = (p - PERIOD_STEP < MIN_PERIOD) ? MIN_PERIOD : p - PERIOD_STEP;
      else if (keys[1] && !keys_prev[1])
        p = (p + PERIOD_STEP > MAX_PERIOD) ? MAX_PERIOD : p + PERIOD_STEP;
      if (16'(p) != exp_period || exp_play != player_pkg::PLAYING)
        armed = 1'b0;
      keys_prev  <= keys;
      exp_period <= 16'(p);
      ref_word   <= w;
      ref_byte   <= b;
      gap_armed  <= armed;
    end
  end

  // Read channel history
  always @(posedge CLK_50M or negedge rst_n)
  begin
    if (!rst_n)
    begin
      ar_wait_q <= 1'b0;
      ar_q      <= '0;
      rd_busy   <= 1'b0;
    end
    else
    begin
      ar_wait_q <= ar.valid && !ar_ready;
      ar_q      <= ar;
      if (ar.valid && ar_ready)
        rd_busy <= 1'b1;
      else if (r.valid && r_ready)
        rd_busy <= 1'b0;
    end
  end

  // ========================================
  // Checks
  // ========================================

  idle_chk: assert property (@(posedge CLK_50M) disable iff (!rst_n)
    reset_idle |-> (!ar.valid && !r_ready && !sample.valid))
    else report_and_stop($sformatf(
      "CHECK FAILED at %0t: ar.valid/r_ready/sample.valid expected 000 actual %b%b%b",
      $time, $sampled(ar.valid), $sampled(r_ready), $sampled(sample.valid)));

  status_chk: assert property (@(posedge CLK_50M) disable iff (!rst_n)
    status.play == exp_play && status.dir == exp_dir)
    else report_and_stop($sformatf("CHECK FAILED at %0t: status expected %b%b actual %b",
      $time, $sampled(exp_play), $sampled(exp_dir), $sampled(status)));

  period_chk: assert property (@(posedge CLK_50M) disable iff (!rst_n)
    period == exp_period)
    else report_and_stop($sformatf("CHECK FAILED at %0t: period expected %0d actual %0d",
      $time, $sampled(exp_period), $sampled(period)));

  data_chk: assert property (@(posedge CLK_50M) disable iff (!rst_n)
    sample.valid |-> sample.data == exp_byte)
    else report_and_stop($sformatf("CHECK FAILED at %0t: sample.data expected %02h actual %02h",
      $time, $sampled(exp_byte), $sampled(sample.data)));

  spacing_chk: assert property (@(posedge CLK_50M) disable iff (!rst_n)
    (sample.valid && gap_armed) |-> gap == int'(exp_period))
    else report_and_stop($sformatf("CHECK FAILED at %0t: sample spacing expected %0d actual %0d",
      $time, $sampled(exp_period), $sampled(gap)));

  quiet_chk: assert property (@(posedge CLK_50M) disable iff (!rst_n)
    quiet |-> !sample.valid)
    else report_and_stop($sformatf("CHECK FAILED at %0t: sample.valid expected 0 actual 1",
      $time));

  ar_hold_chk: assert property (@(posedge CLK_50M) disable iff (!rst_n)
    ar_wait_q |-> (ar == ar_q))
    else report_and_stop($sformatf("CHECK FAILED at %0t: ar expected %h actual %h",
      $time, $sampled(ar_q), $sampled(ar)));

  ar_addr_chk: assert property (@(posedge CLK_50M) disable iff (!rst_n)
    ar.valid |-> (ar.addr[1:0] == 2'b00 && ar.addr < ADDR_LIMIT))
    else report_and_stop($sformatf("Read address %h is unaligned or beyond the song at %0t",
      $sampled(ar.addr), $time));

  outstanding_chk: assert property (@(posedge CLK_50M) disable iff (!rst_n)
    ar.valid |-> !rd_busy)
    else report_and_stop($sformatf("A second read address was issued at %0t before the data",
      $time));

  r_ready_chk: assert property (@(posedge CLK_50M) disable iff (!rst_n)
    r.valid |-> r_ready)
    else report_and_stop($sformatf("Read data was offered at %0t while r_ready was low",
      $time));

  // ========================================
  // Stimulus
  // ========================================

  task automatic send_key(input logic [7:0] code);
    @(negedge CLK_50M);
    key_ascii = code;
    key_valid = 1'b1;
    @(negedge CLK_50M);
    key_valid = 1'b0;
    key_ascii = 8'h00;
  endtask

  // Bit 0 up, bit 1 down, bit 2 reset
  task automatic press_speed(input logic [2:0] sel);
    @(negedge CLK_50M);
    {speed_reset, speed_down, speed_up} = sel;
    repeat (3) @(negedge CLK_50M);
    {speed_reset, speed_down, speed_up} = 3'b000;
    repeat (3) @(negedge CLK_50M);
  endtask

  task automatic wait_samples(input int n);
    int target;
    int limit;
    target = sample_count + n;
    limit  = n * 2 * MAX_PERIOD + 100;
    while (sample_count < target)
    begin
      @(negedge CLK_50M);
      limit = limit - 1;
      if (limit == 0)
        report_and_stop($sformatf("Timed out waiting for %0d samples", n));
    end
  endtask

  initial
  begin
    void'($urandom(SEED));
    rst_n       = 1'b0;
    key_ascii   = 8'h00;
    key_valid   = 1'b0;
    speed_up    = 1'b0;
    speed_down  = 1'b0;
    speed_reset = 1'b0;
    reset_idle  = 1'b0;
    quiet       = 1'b0;
    for (int i = 0; i < SONG_WORDS; i++)
    begin
      song[i]       = $urandom;
      flash0.mem[i] = song[i];
    end
    repeat (8) @(posedge CLK_50M);
    @(negedge CLK_50M);
    rst_n      = 1'b1;
    reset_idle = 1'b1;
    repeat (30) @(negedge CLK_50M);
    reset_idle = 1'b0;

    // Forward play through the wrap
    send_key(player_pkg::key_start);
    wait_samples(40);

    // Backward play, then restarts in both directions
    send_key(player_pkg::key_backward);
    wait_samples(40);
    send_key(player_pkg::key_restart);
    wait_samples(3);
    send_key(player_pkg::key_forward);
    send_key(player_pkg::key_restart);
    wait_samples(3);

    // Stop and resume
    send_key(player_pkg::key_stop);
    repeat (2) @(negedge CLK_50M);
    quiet = 1'b1;
    repeat (200) @(negedge CLK_50M);
    quiet = 1'b0;
    send_key(player_pkg::key_start);
    wait_samples(6);

    // Speed keys up to both limits
    repeat (4)
    begin
      press_speed(3'b001);
      wait_samples(4);
    end
    repeat (7)
    begin
      press_speed(3'b010);
      wait_samples(3);
    end
    press_speed(3'b100);
    wait_samples(4);

    $display("PASS: all tests");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog/audio_player_top.sv ====
`default_nettype none

module audio_player_top #(
  parameter int SONG_WORDS     = 32'h80000,
  // About 22 kHz from the 50 MHz clock
  parameter int DEFAULT_PERIOD = 2268,
  parameter int PERIOD_STEP    = 64,
  parameter int MIN_PERIOD     = 256,
  parameter int MAX_PERIOD     = 16000
) (
  input  wire                          CLK_50M,
  input  wire                          rst_n,
  input  wire  [7:0]                   key_ascii,
  input  wire                          key_valid,
  input  wire                          speed_up,
  input  wire                          speed_down,
  input  wire                          speed_reset,
  output logic [15:0]                  period,
  output player_pkg::player_status_t   status,
  output player_pkg::sample_t          sample,
  output axil_pkg::axil_ar_t           ar,
  input  wire                          ar_ready,
  input  wire  axil_pkg::axil_r_t      r,
  output logic                         r_ready
);

  logic                        restart;
  logic                        tick;
  logic                        fetch_req;
  logic [axil_pkg::ADDR_W-3:0] fetch_word;
  logic [axil_pkg::DATA_W-1:0] fetch_data;
  logic                        fetch_done;

  command_decoder cmd0 (
    .CLK_50M   (CLK_50M),
    .rst_n     (rst_n),
    .key_ascii (key_ascii),
    .key_valid (key_valid),
    .status    (status),
    .restart   (restart)
  );

  sample_rate_gen #(
    .DEFAULT_PERIOD (DEFAULT_PERIOD),
    .PERIOD_STEP    (PERIOD_STEP),
    .MIN_PERIOD     (MIN_PERIOD),
    .MAX_PERIOD     (MAX_PERIOD)
  ) rate0 (
    .CLK_50M     (CLK_50M),
    .rst_n       (rst_n),
    .speed_up    (speed_up),
    .speed_down  (speed_down),
    .speed_reset (speed_reset),
    .period      (period),
    .tick        (tick)
  );

  // Flash side
  flash_axil_reader rd0 (
    .CLK_50M    (CLK_50M),
    .rst_n      (rst_n),
    .fetch_req  (fetch_req),
    .fetch_word (fetch_word),
    .fetch_data (fetch_data),
    .fetch_done (fetch_done),
    .ar         (ar),
    .ar_ready   (ar_ready),
    .r          (r),
    .r_ready    (r_ready)
  );

  sample_sequencer #(
    .SONG_WORDS (SONG_WORDS)
  ) seq0 (
    .CLK_50M    (CLK_50M),
    .rst_n      (rst_n),
    .status     (status),
    .restart    (restart),
    .tick       (tick),
    .fetch_req  (fetch_req),
    .fetch_word (fetch_word),
    .fetch_data (fetch_data),
    .fetch_done (fetch_done),
    .sample     (sample)
  );

endmodule

`default_nettype wire

// ==== verilog/axil_pkg.sv ====
`default_nettype none

package axil_pkg;

  localparam int DATA_W = 32;
  // Byte address, a 23-bit word index plus two byte bits
  localparam int ADDR_W = 25;

  localparam logic [1:0] RESP_OKAY = 2'b00;

  // Read address channel
  typedef struct packed {
    logic              valid;
    logic [ADDR_W-1:0] addr;
    logic [2:0]        prot;
  } axil_ar_t;

  // Read data channel
  typedef struct packed {
    logic              valid;
    logic [DATA_W-1:0] data;
    logic [1:0]        resp;
  } axil_r_t;

endpackage

`default_nettype wire

// ==== verilog/command_decoder.sv ====
`default_nettype none

module command_decoder (
  input  wire                         CLK_50M,
  input  wire                         rst_n,
  input  wire  [7:0]                  key_ascii,
  input  wire                         key_valid,
  output player_pkg::player_status_t status,
  output logic                        restart
);

  player_pkg::player_op_e     op;
  player_pkg::player_status_t status_q;
  logic                       restart_q;
  logic                       started_q;

  // ASCII to opcode
  always_comb
  begin
    case (key_ascii)
      player_pkg::key_start:    op = player_pkg::START;
      player_pkg::key_stop:     op = player_pkg::STOP;
      player_pkg::key_backward: op = player_pkg::BACKWARD;
      player_pkg::key_forward:  op = player_pkg::FORWARD;
      player_pkg::key_restart:  op = player_pkg::RESTART;
      default:                  op = player_pkg::NONE;
    endcase
  end

  always_ff @(posedge CLK_50M or negedge rst_n)
  begin
    if (!rst_n)
    begin
      status_q.play <= player_pkg::STOPPED;
      status_q.dir  <= player_pkg::FWD;
      restart_q     <= 1'b0;
      started_q     <= 1'b0;
    end
    else
    begin
      restart_q <= 1'b0;
      if (key_valid)
      begin
        case (op)
          player_pkg::START:
          begin
            status_q.play <= player_pkg::PLAYING;
            // First start loads the song from its beginning
            restart_q     <= ~started_q;
            started_q     <= 1'b1;
          end
          player_pkg::STOP:     status_q.play <= player_pkg::STOPPED;
          player_pkg::BACKWARD: status_q.dir  <= player_pkg::BWD;
          player_pkg::FORWARD:  status_q.dir  <= player_pkg::FWD;
          player_pkg::RESTART:  restart_q     <= 1'b1;
          default:              restart_q     <= 1'b0;
        endcase
      end
    end
  end

  assign status  = status_q;
  assign restart = restart_q;

endmodule

`default_nettype wire

// ==== verilog/flash_axil_reader.sv ====
`default_nettype none

module flash_axil_reader (
  input  wire                          CLK_50M,
  input  wire                          rst_n,
  input  wire                          fetch_req,
  input  wire  [axil_pkg::ADDR_W-3:0]  fetch_word,
  output logic [axil_pkg::DATA_W-1:0]  fetch_data,
  output logic                         fetch_done,
  output axil_pkg::axil_ar_t           ar,
  input  wire                          ar_ready,
  input  wire  axil_pkg::axil_r_t      r,
  output logic                         r_ready
);

  typedef enum logic [1:0] {IDLE, ADDR, DATA} rd_state_e;

  rd_state_e                   state_q;
  logic [axil_pkg::ADDR_W-1:0] addr_q;
  logic [axil_pkg::DATA_W-1:0] data_q;
  logic                        done_q;

  always_ff @(posedge CLK_50M or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state_q <= IDLE;
      done_q  <= 1'b0;
    end
    else
    begin
      done_q <= 1'b0;
      case (state_q)
        IDLE:
          if (fetch_req)
            state_q <= ADDR;
        // Address held until the slave takes it
        ADDR:
          if (ar_ready)
            state_q <= DATA;
        DATA:
          if (r.valid)
          begin
            done_q  <= 1'b1;
            state_q <= IDLE;
          end
        default: state_q <= IDLE;
      endcase
    end
  end

  always_ff @(posedge CLK_50M)
  begin
    if (state_q == IDLE && fetch_req)
      addr_q <= {fetch_word, 2'b00};
    if (state_q == DATA && r.valid)
      data_q <= r.data;
  end

  always_comb
  begin
    ar.valid = (state_q == ADDR);
    ar.addr  = addr_q;
    ar.prot  = 3'b000;
  end

  assign r_ready    = (state_q == DATA);
  assign fetch_done = done_q;
  assign fetch_data = data_q;

endmodule

`default_nettype wire

// ==== verilog/player_pkg.sv ====
`default_nettype none

package player_pkg;

  // ========================================
  // Commands
  // ========================================

  typedef enum logic [2:0] {
    NONE,
    START,
    STOP,
    BACKWARD,
    FORWARD,
    RESTART
  } player_op_e;

  // ASCII codes of the command keys
  localparam logic [7:0] key_start    = 8'h45;
  localparam logic [7:0] key_stop     = 8'h44;
  localparam logic [7:0] key_backward = 8'h42;
  localparam logic [7:0] key_forward  = 8'h46;
  localparam logic [7:0] key_restart  = 8'h52;

  // ========================================
  // Player state and samples
  // ========================================

  localparam int SAMPLE_W       = 8;
  localparam int BYTES_PER_WORD = 4;

  typedef enum logic {STOPPED, PLAYING} play_state_e;
  typedef enum logic {FWD, BWD} dir_e;

  typedef struct packed {
    play_state_e play;
    dir_e        dir;
  } player_status_t;

  typedef struct packed {
    logic                       valid;
    logic signed [SAMPLE_W-1:0] data;
  } sample_t;

  // Sequencer word buffer states
  typedef enum logic [1:0] {IDLE, FETCH, READY} seq_state_e;

endpackage

`default_nettype wire

// ==== verilog/sample_rate_gen.sv ====
`default_nettype none

module sample_rate_gen #(
  parameter int DEFAULT_PERIOD,
  parameter int PERIOD_STEP,
  parameter int MIN_PERIOD,
  parameter int MAX_PERIOD
) (
  input  wire         CLK_50M,
  input  wire         rst_n,
  input  wire         speed_up,
  input  wire         speed_down,
  input  wire         speed_reset,
  output logic [15:0] period,
  output logic        tick
);

  logic [2:0]  keys;
  logic [2:0]  keys_q;
  logic [2:0]  rise;
  logic [15:0] period_q;
  logic [15:0] period_d;
  logic [15:0] cnt_q;

  // Bit 0 up, bit 1 down, bit 2 reset
  assign keys = {speed_reset, speed_down, speed_up};
  assign rise = keys & ~keys_q;

  // ========================================
  // Period update with clamping
  // ========================================

  always_comb
  begin
    period_d = period_q;
    if (rise[2])
    begin
      period_d = 16'(DEFAULT_PERIOD);
    end
    else if (rise[0])
    begin
      if (period_q < 16'(MIN_PERIOD + PERIOD_STEP))
        period_d = 16'(MIN_PERIOD);
      else
        period_d = period_q - 16'(PERIOD_STEP);
    end
    else if (rise[1])
    begin
      if (period_q > 16'(MAX_PERIOD - PERIOD_STEP))
        period_d = 16'(MAX_PERIOD);
      else
        period_d = period_q + 16'(PERIOD_STEP);
    end
  end

  // ========================================
  // Tick counter
  // ========================================

  always_ff @(posedge CLK_50M or negedge rst_n)
  begin
    if (!rst_n)
    begin
      keys_q   <= 3'b000;
      period_q <= 16'(DEFAULT_PERIOD);
      cnt_q    <= 16'(DEFAULT_PERIOD - 1);
    end
    else
    begin
      keys_q   <= keys;
      period_q <= period_d;
      // Start a fresh period on expiry or on any speed change
      if (cnt_q == 16'd0 || period_d != period_q)
        cnt_q <= period_d - 16'd1;
      else
        cnt_q <= cnt_q - 16'd1;
    end
  end

  assign period = period_q;
  assign tick   = (cnt_q == 16'd0);

endmodule

`default_nettype wire

// ==== verilog/sample_sequencer.sv ====
`default_nettype none

module sample_sequencer #(
  parameter int SONG_WORDS
) (
  input  wire                          CLK_50M,
  input  wire                          rst_n,
  input  wire  player_pkg::player_status_t status,
  input  wire                          restart,
  input  wire                          tick,
  output logic                         fetch_req,
  output logic [axil_pkg::ADDR_W-3:0]  fetch_word,
  input  wire  [axil_pkg::DATA_W-1:0]  fetch_data,
  input  wire                          fetch_done,
  output player_pkg::sample_t          sample
);

  localparam int WORD_W = axil_pkg::ADDR_W - 2;
  localparam int BYTE_W = $clog2(player_pkg::BYTES_PER_WORD);
  localparam logic [WORD_W-1:0] LAST_WORD = WORD_W'(SONG_WORDS - 1);
  localparam logic [BYTE_W-1:0] LAST_BYTE = BYTE_W'(player_pkg::BYTES_PER_WORD - 1);

  player_pkg::seq_state_e                 state_q;
  logic [WORD_W-1:0]                      word_q;
  logic [BYTE_W-1:0]                      byte_q;
  logic [axil_pkg::DATA_W-1:0]            buf_q;
  logic                                   fetch_req_q;
  logic                                   refetch_q;
  logic                                   sample_valid_q;
  logic signed [player_pkg::SAMPLE_W-1:0] sample_data_q;
  logic signed [player_pkg::SAMPLE_W-1:0] cur_byte;
  logic [WORD_W-1:0]                      step_word;
  logic [BYTE_W-1:0]                      step_byte;
  logic                                   leave_word;
  logic [WORD_W-1:0]                      restart_word;
  logic [BYTE_W-1:0]                      restart_byte;
  logic                                   fwd;

  assign fwd          = (status.dir == player_pkg::FWD);
  assign cur_byte     = buf_q[byte_q * player_pkg::SAMPLE_W +: player_pkg::SAMPLE_W];
  assign restart_word = fwd ? '0 : LAST_WORD;
  assign restart_byte = fwd ? '0 : LAST_BYTE;

  // ========================================
  // Pointer step with wrap at song ends
  // ========================================

  always_comb
  begin
    step_word  = word_q;
    step_byte  = byte_q;
    leave_word = 1'b0;
    if (fwd)
    begin
      step_byte = byte_q + 1'b1;
      if (byte_q == LAST_BYTE)
      begin
        step_byte  = '0;
        step_word  = (word_q == LAST_WORD) ? '0 : word_q + 1'b1;
        leave_word = 1'b1;
      end
    end
    else
    begin
      step_byte = byte_q - 1'b1;
      if (byte_q == '0)
      begin
        step_byte  = LAST_BYTE;
        step_word  = (word_q == '0) ? LAST_WORD : word_q - 1'b1;
        leave_word = 1'b1;
      end
    end
  end

  // ========================================
  // Fetch and playback FSM
  // ========================================

  always_ff @(posedge CLK_50M or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state_q        <= player_pkg::IDLE;
      word_q         <= '0;
      byte_q         <= '0;
      fetch_req_q    <= 1'b0;
      refetch_q      <= 1'b0;
      sample_valid_q <= 1'b0;
    end
    else
    begin
      fetch_req_q    <= 1'b0;
      sample_valid_q <= 1'b0;
      case (state_q)
        player_pkg::IDLE:
          if (restart)
          begin
            word_q      <= restart_word;
            byte_q      <= restart_byte;
            fetch_req_q <= 1'b1;
            state_q     <= player_pkg::FETCH;
          end
        player_pkg::FETCH:
        begin
          // Ticks are dropped here
          if (restart)
          begin
            word_q <= restart_word;
            byte_q <= restart_byte;
          end
          if (fetch_done)
          begin
            if (refetch_q || restart)
            begin
              fetch_req_q <= 1'b1;
              refetch_q   <= 1'b0;
            end
            else
            begin
              state_q <= player_pkg::READY;
            end
          end
          else if (restart)
          begin
            refetch_q <= 1'b1;
          end
        end
        player_pkg::READY:
          if (restart)
          begin
            word_q      <= restart_word;
            byte_q      <= restart_byte;
            fetch_req_q <= 1'b1;
            state_q     <= player_pkg::FETCH;
          end
          else if (tick && status.play == player_pkg::PLAYING)
          begin
            sample_valid_q <= 1'b1;
            word_q         <= step_word;
            byte_q         <= step_byte;
            if (leave_word)
            begin
              fetch_req_q <= 1'b1;
              state_q     <= player_pkg::FETCH;
            end
          end
        default: state_q <= player_pkg::IDLE;
      endcase
    end
  end

  always_ff @(posedge CLK_50M)
  begin
    if (fetch_done)
      buf_q <= fetch_data;
    if (tick)
      sample_data_q <= cur_byte;
  end

  always_comb
  begin
    sample.valid = sample_valid_q;
    sample.data  = sample_data_q;
  end

  assign fetch_req  = fetch_req_q;
  assign fetch_word = word_q;

endmodule

`default_nettype wire
